//--- src.f
src/dcache_pkg.sv
src/dcache_tag_array.sv
src/dcache_data_array.sv
src/dcache_mem_port.sv
src/dcache_ctrl.sv
src/dcache_top.sv
test/dcache_checker.sv
test/dcache_tb.sv

//--- Bender.yml
package:
  name: dcache

sources:
  - files:
      - src/dcache_pkg.sv
      - src/dcache_tag_array.sv
      - src/dcache_data_array.sv
      - src/dcache_mem_port.sv
      - src/dcache_ctrl.sv
      - src/dcache_top.sv
  - target: test
    files:
      - test/dcache_checker.sv
      - test/dcache_tb.sv

//--- test/dcache_tb.sv
`timescale 1ns/10ps

module dcache_tb import dcache_pkg::*; ();

  typedef enum logic {OP_READ, OP_WRITE} op_t;

  localparam int    clk_period       = 40;
  localparam int    rst_cycles       = 5;
  localparam int    max_entries      = 32;
  localparam int    cycles_per_entry = 2 * words_per_line * num_ways + 10;
  localparam word_t mem_pattern      = 32'h5a3c_96e1;
  localparam int    mem_words        = 4096;

  logic  clk = 1'b0;
  logic  rst = 1'b1;
  logic  req;
  logic  wreq;
  strb_t wbyte;
  addr_t addr;
  word_t din;
  logic  exp_hit;
  word_t rdata;
  logic  ok;
  logic  miss;
  logic  wen;
  logic  sen;
  addr_t waddr;
  addr_t raddr;
  word_t wdata;
  logic  wdata_ok;
  logic  rdata_ok;
  word_t sdata;
  int    value_errors;
  int    proto_errors;
  int    range_errors = 0;

  // Stimulus table with one array per column
  op_t   tbl_op    [max_entries];
  addr_t tbl_addr  [max_entries];
  strb_t tbl_wbyte [max_entries];
  word_t tbl_din   [max_entries];
  logic  tbl_hit   [max_entries];
  int    n_entries   = 0;
  logic  table_ready = 1'b0;

  word_t  mem_model [mem_words];
  integer seed   = 76;
  int     rd_idx = 0;
  int     wr_idx = 0;

  always #(clk_period / 2) clk = ~clk;

  dcache_top DUT (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .wreq     (wreq),
    .wbyte    (wbyte),
    .addr     (addr),
    .din      (din),
    .rdata    (rdata),
    .ok       (ok),
    .miss     (miss),
    .wen      (wen),
    .sen      (sen),
    .waddr    (waddr),
    .raddr    (raddr),
    .wdata    (wdata),
    .wdata_ok (wdata_ok),
    .rdata_ok (rdata_ok),
    .sdata    (sdata)
  );

  dcache_checker u_checker (
    .clk          (clk),
    .rst          (rst),
    .req          (req),
    .wreq         (wreq),
    .wbyte        (wbyte),
    .addr         (addr),
    .din          (din),
    .exp_hit      (exp_hit),
    .rdata        (rdata),
    .ok           (ok),
    .miss         (miss),
    .wen          (wen),
    .sen          (sen),
    .value_errors (value_errors),
    .proto_errors (proto_errors)
  );

  task automatic add_entry(op_t op, addr_t a, strb_t be, word_t d, logic hit);
    tbl_op[n_entries]    = op;
    tbl_addr[n_entries]  = a;
    tbl_wbyte[n_entries] = be;
    tbl_din[n_entries]   = d;
    tbl_hit[n_entries]   = hit;
    n_entries++;
  endtask

  task automatic load_table();
    add_entry(OP_READ,  32'h2040, 4'b0000, 32'h0,         1'b0);  // Cold miss in set 1
    add_entry(OP_READ,  32'h2048, 4'b0000, 32'h0,         1'b1);
    add_entry(OP_WRITE, 32'h2048, 4'b0101, 32'h1122_3344, 1'b1);  // Partial write hit
    add_entry(OP_READ,  32'h2048, 4'b0000, 32'h0,         1'b1);
    add_entry(OP_WRITE, 32'h3184, 4'b1111, 32'hcafe_f00d, 1'b0);  // Write allocate in set 6
    add_entry(OP_READ,  32'h3180, 4'b0000, 32'h0,         1'b1);
    add_entry(OP_READ,  32'h3184, 4'b0000, 32'h0,         1'b1);
    add_entry(OP_READ,  32'h2440, 4'b0000, 32'h0,         1'b0);  // Fill remaining ways
    add_entry(OP_READ,  32'h2840, 4'b0000, 32'h0,         1'b0);
    add_entry(OP_READ,  32'h2c40, 4'b0000, 32'h0,         1'b0);
    add_entry(OP_READ,  32'h3040, 4'b0000, 32'h0,         1'b0);  // Evicts dirty way 0
    add_entry(OP_READ,  32'h2048, 4'b0000, 32'h0,         1'b0);
    add_entry(OP_WRITE, 32'h2c44, 4'b1010, 32'h5a6b_7c8d, 1'b1);
    add_entry(OP_READ,  32'h3440, 4'b0000, 32'h0,         1'b0);
    add_entry(OP_READ,  32'h3840, 4'b0000, 32'h0,         1'b0);
    add_entry(OP_READ,  32'h2440, 4'b0000, 32'h0,         1'b0);
    add_entry(OP_READ,  32'h2040, 4'b0000, 32'h0,         1'b0);  // Evicts dirty way 3
    add_entry(OP_READ,  32'h2c44, 4'b0000, 32'h0,         1'b0);
    add_entry(OP_READ,  32'h2048, 4'b0000, 32'h0,         1'b1);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Memory model with random strobe stalls
  //////////////////////////////////////////////////////////////////////
  function automatic logic in_range(addr_t a);
    return a[addr_w-1:14] == '0;
  endfunction

  always @(negedge clk)
  begin
    wdata_ok = 1'b0;
    rdata_ok = 1'b0;
    if (wen !== 1'b1)
      wr_idx = 0;
    else if (($random(seed) & 3) != 0)   // Stall one cycle in four
    begin
      if (!in_range(waddr + addr_t'(wr_idx * 4)))
      begin
        range_errors++;
        $display("Write-back address %h is outside the memory model", waddr);
      end
      mem_model[(waddr[13:2] + wr_idx) % mem_words] = wdata;
      wdata_ok = 1'b1;
      wr_idx++;
    end
    if (sen !== 1'b1)
      rd_idx = 0;
    else if (($random(seed) & 3) != 0)
    begin
      if (!in_range(raddr + addr_t'(rd_idx * 4)))
      begin
        range_errors++;
        $display("Refill address %h is outside the memory model", raddr);
      end
      sdata    = mem_model[(raddr[13:2] + rd_idx) % mem_words];
      rdata_ok = 1'b1;
      rd_idx++;
    end
  end

  initial
  begin
    req      = 1'b0;
    wreq     = 1'b0;
    wbyte    = '0;
    addr     = '0;
    din      = '0;
    exp_hit  = 1'b0;
    wdata_ok = 1'b0;
    rdata_ok = 1'b0;
    sdata    = '0;
    for (int i = 0; i < mem_words; i++)
      mem_model[i] = addr_t'(i << 2) ^ mem_pattern;
    load_table();
    table_ready = 1'b1;
    repeat (rst_cycles) @(negedge clk);
    rst = 1'b0;
    for (int i = 0; i < n_entries; i++)
    begin
      @(negedge clk);
      req     = 1'b1;
      wreq    = (tbl_op[i] == OP_WRITE);
      wbyte   = tbl_wbyte[i];
      addr    = tbl_addr[i];
      din     = tbl_din[i];
      exp_hit = tbl_hit[i];
      @(negedge clk);
      req = 1'b0;
      do
        @(posedge clk);
      while (ok !== 1'b1);
    end
    repeat (2) @(negedge clk);
    $display("Errors: %0d data, %0d protocol, %0d memory range", value_errors, proto_errors,
             range_errors);
    if (value_errors == 0 && proto_errors == 0 && range_errors == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

  // Watchdog
  initial
  begin
    wait (table_ready === 1'b1);
    #(n_entries * cycles_per_entry * clk_period);
    $display("Timeout: requests did not complete within %0d cycles",
             n_entries * cycles_per_entry);
    $display("Simulation failed");
    $finish;
  end

endmodule

//--- test/dcache_checker.sv
`timescale 1ns/10ps

module dcache_checker import dcache_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  req,
  input  logic  wreq,
  input  strb_t wbyte,
  input  addr_t addr,
  input  word_t din,
  input  logic  exp_hit,
  input  word_t rdata,
  input  logic  ok,
  input  logic  miss,
  input  logic  wen,
  input  logic  sen,
  output int    value_errors,
  output int    proto_errors
);

  localparam word_t mem_pattern = 32'h5a3c_96e1;
  localparam int    mem_words   = 4096;

  word_t ref_mem [mem_words];   // Flat image of main memory
  logic  busy;
  int    cycles;
  logic  wreq_q;
  strb_t wbyte_q;
  addr_t addr_q;
  word_t din_q;
  logic  exp_hit_q;
  word_t expected;

  function automatic word_t merge_bytes(word_t old_w, word_t new_w, strb_t be);
    word_t mask;
    for (int b = 0; b < strb_w; b++)
      mask[b*8 +: 8] = {8{be[b]}};
    return (old_w & ~mask) | (new_w & mask);
  endfunction

  task automatic report_mismatch(string msg);
    value_errors++;
    $display("CHECK FAILED at %0d ns: %s", $time, msg);
  endtask

  initial
  begin
    value_errors = 0;
    proto_errors = 0;
    busy         = 1'b0;
    cycles       = 0;
    for (int i = 0; i < mem_words; i++)
      ref_mem[i] = addr_t'(i << 2) ^ mem_pattern;
  end

  always @(negedge clk)
  begin
    if (rst === 1'b1 && (ok !== 1'b0 || miss !== 1'b0 || wen !== 1'b0 || sen !== 1'b0))
      report_mismatch("ok, miss, wen or sen not low during reset");
  end

  //////////////////////////////////////////////////////////////////////
  // Request tracking and result compare
  //////////////////////////////////////////////////////////////////////
  always @(posedge clk)
  begin
    if (rst === 1'b1)
      busy = 1'b0;
    else if (busy)
    begin
      cycles++;
      if (miss !== !exp_hit_q)   // Held from lookup up to ok
        report_mismatch($sformatf("miss is %b in cycle %0d of %h", miss, cycles, addr_q));
      if (ok === 1'b1)
      begin
        if (exp_hit_q && cycles != 1)
          report_mismatch($sformatf("hit on %h took %0d cycles", addr_q, cycles));
        expected = ref_mem[addr_q[13:2]];
        if (wreq_q)
        begin
          expected                = merge_bytes(expected, din_q, wbyte_q);
          ref_mem[addr_q[13:2]] = expected;
        end
        if (rdata !== expected)
          report_mismatch($sformatf("addr %h rdata %h expected %h", addr_q, rdata, expected));
        busy = 1'b0;
      end
    end
    else
    begin
      if (ok === 1'b1)
      begin
        proto_errors++;
        $display("Protocol error at %0d ns: ok arrived with no request outstanding", $time);
      end
      if (req === 1'b1)
      begin
        busy      = 1'b1;
        cycles    = 0;
        wreq_q    = wreq;
        wbyte_q   = wbyte;
        addr_q    = addr;
        din_q     = din;
        exp_hit_q = exp_hit;
      end
    end
  end

endmodule

//--- src/dcache_top.sv
`timescale 1ns/10ps

module dcache_top import dcache_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  // CPU side
  input  logic  req,
  input  logic  wreq,
  input  strb_t wbyte,
  input  addr_t addr,
  input  word_t din,
  output word_t rdata,
  output logic  ok,
  output logic  miss,
  // Memory side
  output logic  wen,
  output logic  sen,
  output addr_t waddr,
  output addr_t raddr,
  output word_t wdata,
  input  logic  wdata_ok,
  input  logic  rdata_ok,
  input  word_t sdata
);

  index_t  index;
  tag_t    tag;
  offset_t offset;
  way_t    way;
  logic    hit;
  way_t    hit_way;
  way_t    victim_way;
  logic    victim_dirty;
  tag_t    victim_tag;
  logic    access;
  logic    fill;
  logic    set_dirty;
  word_t   rd_word;
  logic    wr_en;
  strb_t   wr_strb;
  word_t   wr_word;
  logic    start_wb;
  logic    start_refill;
  logic    wb_done;
  logic    refill_done;
  logic    fill_en;
  offset_t fill_offset;
  word_t   fill_word;
  offset_t wb_offset;
  word_t   wb_word;

  dcache_ctrl u_ctrl (
    .clk          (clk),
    .rst          (rst),
    .req          (req),
    .wreq         (wreq),
    .wbyte        (wbyte),
    .addr         (addr),
    .din          (din),
    .rdata        (rdata),
    .ok           (ok),
    .miss         (miss),
    .index        (index),
    .tag          (tag),
    .offset       (offset),
    .way          (way),
    .hit          (hit),
    .hit_way      (hit_way),
    .victim_way   (victim_way),
    .victim_dirty (victim_dirty),
    .access       (access),
    .fill         (fill),
    .set_dirty    (set_dirty),
    .rd_word      (rd_word),
    .wr_en        (wr_en),
    .wr_strb      (wr_strb),
    .wr_word      (wr_word),
    .start_wb     (start_wb),
    .start_refill (start_refill),
    .wb_done      (wb_done),
    .refill_done  (refill_done)
  );

  dcache_tag_array u_tags (
    .clk          (clk),
    .rst          (rst),
    .index        (index),
    .tag          (tag),
    .way          (way),
    .access       (access),
    .fill         (fill),
    .set_dirty    (set_dirty),
    .hit          (hit),
    .hit_way      (hit_way),
    .victim_way   (victim_way),
    .victim_dirty (victim_dirty),
    .victim_tag   (victim_tag)
  );

  dcache_data_array u_data (
    .clk         (clk),
    .index       (index),
    .way         (way),
    .offset      (offset),
    .rd_word     (rd_word),
    .wr_en       (wr_en),
    .wr_strb     (wr_strb),
    .wr_word     (wr_word),
    .fill_en     (fill_en),
    .fill_offset (fill_offset),
    .fill_word   (fill_word),
    .wb_offset   (wb_offset),
    .wb_word     (wb_word)
  );

  dcache_mem_port u_mem (
    .clk          (clk),
    .rst          (rst),
    .index        (index),
    .victim_tag   (victim_tag),
    .tag          (tag),
    .start_wb     (start_wb),
    .start_refill (start_refill),
    .wb_done      (wb_done),
    .refill_done  (refill_done),
    .wen          (wen),
    .sen          (sen),
    .waddr        (waddr),
    .raddr        (raddr),
    .wdata        (wdata),
    .wb_offset    (wb_offset),
    .wb_word      (wb_word),
    .wdata_ok     (wdata_ok),
    .rdata_ok     (rdata_ok),
    .sdata        (sdata),
    .fill_en      (fill_en),
    .fill_offset  (fill_offset),
    .fill_word    (fill_word)
  );

endmodule

//--- src/dcache_ctrl.sv
`timescale 1ns/10ps

module dcache_ctrl import dcache_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  // CPU side
  input  logic    req,
  input  logic    wreq,
  input  strb_t   wbyte,
  input  addr_t   addr,
  input  word_t   din,
  output word_t   rdata,
  output logic    ok,
  output logic    miss,
  // Array addressing
  output index_t  index,
  output tag_t    tag,
  output offset_t offset,
  output way_t    way,
  // Tag array
  input  logic    hit,
  input  way_t    hit_way,
  input  way_t    victim_way,
  input  logic    victim_dirty,
  output logic    access,
  output logic    fill,
  output logic    set_dirty,
  // Data array
  input  word_t   rd_word,
  output logic    wr_en,
  output strb_t   wr_strb,
  output word_t   wr_word,
  // Memory port
  output logic    start_wb,
  output logic    start_refill,
  input  logic    wb_done,
  input  logic    refill_done
);

  ctrl_state_t state_q, state_d;

  addr_t addr_q;
  logic  wreq_q;
  strb_t wbyte_q;
  word_t din_q;
  way_t  victim_q;
  word_t merged;

  // Request captured only while idle
  always_ff @(posedge clk)
  begin
    if (state_q == ST_IDLE && req)
    begin
      addr_q  <= addr;
      wreq_q  <= wreq;
      wbyte_q <= wbyte;
      din_q   <= din;
    end
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state_q  <= ST_IDLE;
      victim_q <= '0;
    end
    else
    begin
      state_q <= state_d;
      if (state_q == ST_LOOKUP && !hit)
        victim_q <= victim_way;
    end
  end

  assign tag    = addr_q[addr_w-1 -: tag_w];
  assign index  = addr_q[offset_w+byte_off_w +: index_w];
  assign offset = addr_q[byte_off_w +: offset_w];

  assign wr_strb = wbyte_q;
  assign wr_word = din_q;

  // Old word with the enabled bytes replaced
  always_comb
  begin
    for (int b = 0; b < strb_w; b++)
      merged[b*8 +: 8] = wbyte_q[b] ? din_q[b*8 +: 8] : rd_word[b*8 +: 8];
  end

  assign rdata = wreq_q ? merged : rd_word;

  assign miss = (state_q == ST_LOOKUP && !hit) || state_q == ST_WRITE_BACK ||
                state_q == ST_REFILL || state_q == ST_FINISH;

  //////////////////////////////////////////////////////////////////////
  // Request sequencing
  //////////////////////////////////////////////////////////////////////
  always_comb
  begin
    state_d      = state_q;
    way          = victim_q;
    ok           = 1'b0;
    access       = 1'b0;
    fill         = 1'b0;
    set_dirty    = 1'b0;
    wr_en        = 1'b0;
    start_wb     = 1'b0;
    start_refill = 1'b0;
    case (state_q)
      ST_IDLE:
        if (req)
          state_d = ST_LOOKUP;
      ST_LOOKUP:
        if (hit)
        begin
          way       = hit_way;
          ok        = 1'b1;
          access    = 1'b1;     // Age update
          wr_en     = wreq_q;
          set_dirty = wreq_q;
          state_d   = ST_IDLE;
        end
        else
        begin
          way = victim_way;
          if (victim_dirty)
          begin
            start_wb = 1'b1;
            state_d  = ST_WRITE_BACK;
          end
          else
          begin
            start_refill = 1'b1;
            state_d      = ST_REFILL;
          end
        end
      ST_WRITE_BACK:
        if (wb_done)
        begin
          start_refill = 1'b1;
          state_d      = ST_REFILL;
        end
      ST_REFILL:
        if (refill_done)
          state_d = ST_FINISH;
      ST_FINISH:
      begin
        ok        = 1'b1;
        fill      = 1'b1;     // New tag, valid, age 0
        wr_en     = wreq_q;
        set_dirty = wreq_q;
        state_d   = ST_IDLE;
      end
      default:
        state_d = ST_IDLE;
    endcase
  end

endmodule

//--- src/dcache_mem_port.sv
`timescale 1ns/10ps

module dcache_mem_port import dcache_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  index_t  index,
  input  tag_t    victim_tag,
  input  tag_t    tag,
  input  logic    start_wb,
  input  logic    start_refill,
  output logic    wb_done,
  output logic    refill_done,
  output logic    wen,
  output logic    sen,
  output addr_t   waddr,
  output addr_t   raddr,
  output word_t   wdata,
  output offset_t wb_offset,
  input  word_t   wb_word,
  input  logic    wdata_ok,
  input  logic    rdata_ok,
  input  word_t   sdata,
  output logic    fill_en,
  output offset_t fill_offset,
  output word_t   fill_word
);

  localparam offset_t last_word = offset_t'(words_per_line - 1);

  offset_t wb_cnt;
  offset_t rd_cnt;

  // Line-aligned burst addresses
  assign waddr = {victim_tag, index, {(offset_w + byte_off_w){1'b0}}};
  assign raddr = {tag, index, {(offset_w + byte_off_w){1'b0}}};

  assign wb_offset = wb_cnt;
  assign wdata     = wb_word;
  assign wb_done   = wen & wdata_ok & (wb_cnt == last_word);

  assign fill_en     = sen & rdata_ok;
  assign fill_offset = rd_cnt;
  assign fill_word   = sdata;
  assign refill_done = fill_en & (rd_cnt == last_word);

  //////////////////////////////////////////////////////////////////////
  // Burst counters
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      wen    <= 1'b0;
      wb_cnt <= '0;
    end
    else if (start_wb)
    begin
      wen    <= 1'b1;
      wb_cnt <= '0;
    end
    else if (wen && wdata_ok)
    begin
      wb_cnt <= wb_cnt + 1'b1;
      if (wb_cnt == last_word)
        wen <= 1'b0;
    end
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      sen    <= 1'b0;
      rd_cnt <= '0;
    end
    else if (start_refill)
    begin
      sen    <= 1'b1;
      rd_cnt <= '0;
    end
    else if (fill_en)
    begin
      rd_cnt <= rd_cnt + 1'b1;
      if (rd_cnt == last_word)
        sen <= 1'b0;   // Drops the cycle after the last word
    end
  end

endmodule

//--- src/dcache_data_array.sv
`timescale 1ns/10ps

module dcache_data_array import dcache_pkg::*; (
  input  logic    clk,
  input  index_t  index,
  input  way_t    way,
  input  offset_t offset,
  output word_t   rd_word,
  // CPU write
  input  logic    wr_en,
  input  strb_t   wr_strb,
  input  word_t   wr_word,
  // Refill write
  input  logic    fill_en,
  input  offset_t fill_offset,
  input  word_t   fill_word,
  // Write-back read
  input  offset_t wb_offset,
  output word_t   wb_word
);

  word_t mem [num_ways][num_sets][words_per_line];

  // Asynchronous read ports
  assign rd_word = mem[way][index][offset];
  assign wb_word = mem[way][index][wb_offset];

  //////////////////////////////////////////////////////////////////////
  // Write ports
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk)
  begin
    if (fill_en)
      mem[way][index][fill_offset] <= fill_word;
    if (wr_en)
    begin
      for (int b = 0; b < strb_w; b++)
      begin
        if (wr_strb[b])
          mem[way][index][offset][b*8 +: 8] <= wr_word[b*8 +: 8];
      end
    end
  end

endmodule

//--- src/dcache_tag_array.sv
`timescale 1ns/10ps

module dcache_tag_array import dcache_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  index_t index,
  input  tag_t   tag,
  input  way_t   way,
  input  logic   access,
  input  logic   fill,
  input  logic   set_dirty,
  output logic   hit,
  output way_t   hit_way,
  output way_t   victim_way,
  output logic   victim_dirty,
  output tag_t   victim_tag
);

  tag_t                tags  [num_sets][num_ways];
  logic [num_ways-1:0] valid [num_sets];
  logic [num_ways-1:0] dirty [num_sets];
  age_t                ages  [num_sets][num_ways];

  logic found_free;
  age_t oldest;
  age_t cur_age;

  // Parallel compare of all ways
  always_comb
  begin
    hit     = 1'b0;
    hit_way = '0;
    for (int w = 0; w < num_ways; w++)
    begin
      if (!hit && valid[index][w] && tags[index][w] == tag)
      begin
        hit     = 1'b1;
        hit_way = way_t'(w);
      end
    end
  end

  // Victim is the first free way or the oldest with ties to the lowest index
  always_comb
  begin
    found_free = 1'b0;
    oldest     = '0;
    victim_way = '0;
    for (int w = 0; w < num_ways; w++)
    begin
      if (!found_free && !valid[index][w])
      begin
        found_free = 1'b1;
        victim_way = way_t'(w);
      end
    end
    if (!found_free)
    begin
      for (int w = 0; w < num_ways; w++)
      begin
        if (ages[index][w] > oldest)
        begin
          oldest     = ages[index][w];
          victim_way = way_t'(w);
        end
      end
    end
  end

  assign victim_dirty = dirty[index][victim_way];
  assign victim_tag   = tags[index][way];   // Latched victim during write-back
  assign cur_age      = ages[index][way];

  always_ff @(posedge clk)
  begin
    if (fill)
      tags[index][way] <= tag;
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int s = 0; s < num_sets; s++)
      begin
        valid[s] <= '0;
        dirty[s] <= '0;
        for (int w = 0; w < num_ways; w++)
          ages[s][w] <= '0;
      end
    end
    else
    begin
      if (access || fill)
      begin
        for (int w = 0; w < num_ways; w++)
        begin
          if (way_t'(w) == way)
            ages[index][w] <= '0;
          else if (ages[index][w] <= cur_age)
            ages[index][w] <= ages[index][w] + 1'b1;
        end
      end
      if (fill)
        valid[index][way] <= 1'b1;
      if (fill || set_dirty)
        dirty[index][way] <= set_dirty;   // Fill clears unless writing
    end
  end

endmodule

//--- src/dcache_pkg.sv
package dcache_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths and geometry
  //////////////////////////////////////////////////////////////////////
  localparam int addr_w         = 32;
  localparam int data_w         = 32;
  localparam int tag_w          = 22;
  localparam int index_w        = 4;
  localparam int offset_w       = 4;   // Word within a line
  localparam int byte_off_w     = 2;   // Byte within a word
  localparam int num_sets       = 16;
  localparam int words_per_line = 16;
  localparam int num_ways       = 4;
  localparam int way_w          = 2;
  localparam int age_w          = 2;
  localparam int strb_w         = 4;

  // Address layout is tag | index | word offset | byte offset
  typedef logic [addr_w-1:0]   addr_t;
  typedef logic [data_w-1:0]   word_t;
  typedef logic [tag_w-1:0]    tag_t;
  typedef logic [index_w-1:0]  index_t;
  typedef logic [offset_w-1:0] offset_t;
  typedef logic [way_w-1:0]    way_t;
  typedef logic [age_w-1:0]    age_t;
  typedef logic [strb_w-1:0]   strb_t;

  //////////////////////////////////////////////////////////////////////
  // Controller states
  //////////////////////////////////////////////////////////////////////
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LOOKUP,
    ST_WRITE_BACK,
    ST_REFILL,
    ST_FINISH
  } ctrl_state_t;

endpackage
